// File: design/gt_bringup_pkg.sv
package gt_bringup_pkg;

	// number of chained bring-up steps
	localparam int NSTEP = 6;

	// step indices, also the bit positions in criteria and reset vectors
	localparam int STEP_CPLL  = 0;
	localparam int STEP_TXRX0 = 1;
	localparam int STEP_TXRX1 = 2;
	localparam int STEP_TXDLY = 3;
	localparam int STEP_RXDLY = 4;
	localparam int STEP_COMMA = 5;

	// reset pulse length per step, in lock-detect clock cycles
	localparam int RESET_LEN [NSTEP] = '{4, 4, 4, 2, 2, 4};

	// settle time after reset release, before criteria are checked
	localparam int READY_LEN = 4;

	// K28.5, sent with the K flag set
	localparam logic [7:0] COMMA_CHAR = 8'hBC;

	// consecutive unlocked samples before cdr lock is dropped
	localparam int LOCK_MAX = 3;

	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		RESET = 3'd1, // step reset asserted
		READY = 3'd2, // reset released, waiting
		CHECK = 3'd3, // criterion window
		DONE  = 3'd4
	} seq_state_t;

endpackage

// File: design/chain_reset_seq.sv
`timescale 1ns/1ps

module chain_reset_seq #(
	parameter int STEP_TIMEOUT = 64
) (
	input  logic                             CPLLLOCKDETCLK,
	input  logic                             reset,
	input  logic [gt_bringup_pkg::NSTEP-1:0] criteria_i,
	output logic [gt_bringup_pkg::NSTEP-1:0] step_reset_o,
	output logic [gt_bringup_pkg::NSTEP-1:0] step_done_o,
	output logic [2:0]                       state_o,
	output logic                             all_done_o
);

	localparam int NSTEP = gt_bringup_pkg::NSTEP;
	localparam int SW = $clog2(NSTEP);
	// counter must cover the longest phase
	localparam int CMAX = (STEP_TIMEOUT > 16) ? STEP_TIMEOUT : 16;
	localparam int CW = $clog2(CMAX + 1);

	gt_bringup_pkg::seq_state_t state;
	logic [SW-1:0] step;
	logic [CW-1:0] cnt;
	logic [NSTEP-1:0] step_done;
	logic reset_end;
	logic ready_end;
	logic window_end;
	logic crit_hit;

	assign reset_end = (cnt == CW'(gt_bringup_pkg::RESET_LEN[step] - 1));
	assign ready_end = (cnt == CW'(gt_bringup_pkg::READY_LEN - 1));
	assign window_end = (cnt == CW'(STEP_TIMEOUT - 1));
	assign crit_hit = criteria_i[step];

	// one-hot reset for the active step
	always_comb begin
		step_reset_o = '0;
		if (state == gt_bringup_pkg::RESET) begin
			step_reset_o[step] = 1'b1;
		end
	end

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			state      <= gt_bringup_pkg::IDLE;
			step       <= '0;
			cnt        <= '0;
			step_done  <= '0;
			all_done_o <= 1'b0;
		end else begin
			all_done_o <= (&step_done) & criteria_i[gt_bringup_pkg::STEP_TXRX0];
			case (state)
				gt_bringup_pkg::IDLE: begin
					state <= gt_bringup_pkg::RESET;
					step  <= '0;
					cnt   <= '0;
				end
				gt_bringup_pkg::RESET: begin
					if (reset_end) begin
						state <= gt_bringup_pkg::READY;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				gt_bringup_pkg::READY: begin
					if (ready_end) begin
						state <= gt_bringup_pkg::CHECK;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				gt_bringup_pkg::CHECK: begin
					if (crit_hit) begin
						step_done[step] <= 1'b1;
						cnt             <= '0;
						if (step == SW'(NSTEP - 1)) begin
							state <= gt_bringup_pkg::DONE;
						end else begin
							step  <= step + 1'b1; // next step starts its reset now
							state <= gt_bringup_pkg::RESET;
						end
					end else if (window_end) begin
						// timeout, whole chain over again
						step_done <= '0;
						step      <= '0;
						cnt       <= '0;
						state     <= gt_bringup_pkg::RESET;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				gt_bringup_pkg::DONE: begin
					cnt <= '0; // hold until next reset
				end
				default: begin
					state <= gt_bringup_pkg::IDLE;
				end
			endcase
		end
	end

	assign step_done_o = step_done;
	assign state_o = state;

endmodule

// File: design/align_done_tracker.sv
`timescale 1ns/1ps

module align_done_tracker (
	input  logic CPLLLOCKDETCLK,
	input  logic reset,
	input  logic clear_i,
	input  logic phalign_done_i,
	output logic align_done_o
);

	logic done_d;
	logic first;
	logic rising;

	assign rising = phalign_done_i & ~done_d;

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			done_d       <= 1'b0;
			first        <= 1'b1;
			align_done_o <= 1'b0;
		end else begin
			done_d <= phalign_done_i;
			if (clear_i) begin
				first        <= 1'b1;
				align_done_o <= 1'b0;
			end else if (rising) begin
				// first completion after a delay reset is not final
				first <= 1'b0;
				if (!first) begin
					align_done_o <= 1'b1;
				end
			end
		end
	end

endmodule

// File: design/cdr_lock_filter.sv
`timescale 1ns/1ps

module cdr_lock_filter (
	input  logic CPLLLOCKDETCLK,
	input  logic reset,
	input  logic cdr_lock_i,
	output logic cdr_locked_o
);

	localparam int CW = $clog2(gt_bringup_pkg::LOCK_MAX + 1);

	logic [CW-1:0] unlock_cnt;

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			unlock_cnt   <= '0;
			cdr_locked_o <= 1'b0;
		end else if (cdr_lock_i) begin
			unlock_cnt   <= '0;
			cdr_locked_o <= 1'b1;
		end else if (unlock_cnt == CW'(gt_bringup_pkg::LOCK_MAX - 1)) begin
			cdr_locked_o <= 1'b0; // counter saturates here
		end else begin
			unlock_cnt <= unlock_cnt + 1'b1;
		end
	end

endmodule

// File: design/bringup_status.sv
`timescale 1ns/1ps

module bringup_status #(
	parameter int DWIDTH = 16,
	localparam int DBYTE = DWIDTH / 8
) (
	input  logic [gt_bringup_pkg::NSTEP-1:0] mask_i,
	input  logic [gt_bringup_pkg::NSTEP-1:0] step_reset_i,
	input  logic                             cpll_lock_i,
	input  logic                             cpll_fbclk_lost_i,
	input  logic                             cpll_refclk_lost_i,
	input  logic                             tx_reset_done_i,
	input  logic                             rx_reset_done_i,
	input  logic                             mmcm_locked_i,
	input  logic                             rx_elec_idle_i,
	input  logic [DBYTE-1:0]                 rx_notintable_i,
	input  logic [DBYTE-1:0]                 rx_disperr_i,
	input  logic                             tx_align_done_i,
	input  logic                             rx_align_done_i,
	input  logic                             cdr_locked_i,
	output logic [gt_bringup_pkg::NSTEP-1:0] criteria_o,
	output logic [gt_bringup_pkg::NSTEP-1:0] gt_reset_o,
	output logic                             tx_align_clr_o,
	output logic                             rx_align_clr_o
);

	logic [gt_bringup_pkg::NSTEP-1:0] raw;
	logic cpll_ok;
	logic txrx_ok;
	logic txrx_reset;

	assign cpll_ok = cpll_lock_i & ~cpll_fbclk_lost_i & ~cpll_refclk_lost_i;
	assign txrx_ok = tx_reset_done_i & rx_reset_done_i & mmcm_locked_i & cpll_ok;

	always_comb begin
		raw = '0;
		raw[gt_bringup_pkg::STEP_CPLL]  = cpll_ok;
		raw[gt_bringup_pkg::STEP_TXRX0] = txrx_ok;
		raw[gt_bringup_pkg::STEP_TXRX1] = txrx_ok;
		raw[gt_bringup_pkg::STEP_TXDLY] = tx_align_done_i & cdr_locked_i & ~rx_elec_idle_i;
		raw[gt_bringup_pkg::STEP_RXDLY] = rx_align_done_i;
		// byte alignment clean on every lane byte
		raw[gt_bringup_pkg::STEP_COMMA] = rx_align_done_i & ~(|rx_notintable_i)
			& ~(|rx_disperr_i);
	end

	assign criteria_o = raw | ~mask_i; // masked steps pass

	assign gt_reset_o = step_reset_i & mask_i;
	assign txrx_reset = gt_reset_o[gt_bringup_pkg::STEP_TXRX0]
		| gt_reset_o[gt_bringup_pkg::STEP_TXRX1];
	assign tx_align_clr_o = txrx_reset | gt_reset_o[gt_bringup_pkg::STEP_TXDLY];
	assign rx_align_clr_o = txrx_reset | gt_reset_o[gt_bringup_pkg::STEP_RXDLY];

endmodule

// File: design/tx_word_gate.sv
`timescale 1ns/1ps

module tx_word_gate #(
	parameter int DWIDTH = 16,
	localparam int DBYTE = DWIDTH / 8
) (
	input  logic              reset_done_i,
	input  logic [DWIDTH-1:0] tx_data_i,
	input  logic [DBYTE-1:0]  tx_charisk_i,
	output logic [DWIDTH-1:0] tx_data_o,
	output logic [DBYTE-1:0]  tx_charisk_o
);

	logic [DWIDTH-1:0] comma_word;
	logic [DBYTE-1:0] comma_k;

	// comma in byte 0 only, rest idle zero
	assign comma_word = {{(DWIDTH - 8){1'b0}}, gt_bringup_pkg::COMMA_CHAR};
	assign comma_k = {{(DBYTE - 1){1'b0}}, 1'b1};

	always_comb begin
		if (reset_done_i) begin
			tx_data_o    = tx_data_i;
			tx_charisk_o = tx_charisk_i;
		end else begin
			tx_data_o    = comma_word; // keeps the far end aligned during bring-up
			tx_charisk_o = comma_k;
		end
	end

endmodule

// File: design/gt_bringup_top.sv
`timescale 1ns/1ps

module gt_bringup_top #(
	parameter int DWIDTH = 16,
	parameter int STEP_TIMEOUT = 64,
	localparam int DBYTE = DWIDTH / 8
) (
	input  logic                             CPLLLOCKDETCLK,
	input  logic                             reset,
	input  logic [gt_bringup_pkg::NSTEP-1:0] mask_i,
	input  logic                             cpll_lock_i,
	input  logic                             cpll_fbclk_lost_i,
	input  logic                             cpll_refclk_lost_i,
	input  logic                             tx_reset_done_i,
	input  logic                             rx_reset_done_i,
	input  logic                             mmcm_locked_i,
	input  logic                             tx_phalign_done_i,
	input  logic                             rx_phalign_done_i,
	input  logic                             rx_cdr_lock_i,
	input  logic                             rx_elec_idle_i,
	input  logic [DBYTE-1:0]                 rx_notintable_i,
	input  logic [DBYTE-1:0]                 rx_disperr_i,
	input  logic [DWIDTH-1:0]                tx_data_i,
	input  logic [DBYTE-1:0]                 tx_charisk_i,
	output logic [gt_bringup_pkg::NSTEP-1:0] gt_reset_o,
	output logic [gt_bringup_pkg::NSTEP-1:0] step_done_o,
	output logic [2:0]                       seq_state_o,
	output logic [gt_bringup_pkg::NSTEP-1:0] criteria_o,
	output logic                             cdr_locked_o,
	output logic                             reset_done_o,
	output logic [DWIDTH-1:0]                tx_data_o,
	output logic [DBYTE-1:0]                 tx_charisk_o
);

	logic [gt_bringup_pkg::NSTEP-1:0] step_reset; // unmasked
	logic tx_align_done;
	logic rx_align_done;
	logic tx_align_clr;
	logic rx_align_clr;

	chain_reset_seq #(
		.STEP_TIMEOUT(STEP_TIMEOUT)
	) u_chain_reset_seq (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset         (reset),
		.criteria_i    (criteria_o),
		.step_reset_o  (step_reset),
		.step_done_o   (step_done_o),
		.state_o       (seq_state_o),
		.all_done_o    (reset_done_o)
	);

	align_done_tracker u_tx_align (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset         (reset),
		.clear_i       (tx_align_clr),
		.phalign_done_i(tx_phalign_done_i),
		.align_done_o  (tx_align_done)
	);

	align_done_tracker u_rx_align (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset         (reset),
		.clear_i       (rx_align_clr),
		.phalign_done_i(rx_phalign_done_i),
		.align_done_o  (rx_align_done)
	);

	cdr_lock_filter u_cdr_lock_filter (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset         (reset),
		.cdr_lock_i    (rx_cdr_lock_i),
		.cdr_locked_o  (cdr_locked_o)
	);

	bringup_status #(
		.DWIDTH(DWIDTH)
	) u_bringup_status (
		.mask_i            (mask_i),
		.step_reset_i      (step_reset),
		.cpll_lock_i       (cpll_lock_i),
		.cpll_fbclk_lost_i (cpll_fbclk_lost_i),
		.cpll_refclk_lost_i(cpll_refclk_lost_i),
		.tx_reset_done_i   (tx_reset_done_i),
		.rx_reset_done_i   (rx_reset_done_i),
		.mmcm_locked_i     (mmcm_locked_i),
		.rx_elec_idle_i    (rx_elec_idle_i),
		.rx_notintable_i   (rx_notintable_i),
		.rx_disperr_i      (rx_disperr_i),
		.tx_align_done_i   (tx_align_done),
		.rx_align_done_i   (rx_align_done),
		.cdr_locked_i      (cdr_locked_o),
		.criteria_o        (criteria_o),
		.gt_reset_o        (gt_reset_o),
		.tx_align_clr_o    (tx_align_clr),
		.rx_align_clr_o    (rx_align_clr)
	);

	tx_word_gate #(
		.DWIDTH(DWIDTH)
	) u_tx_word_gate (
		.reset_done_i(reset_done_o),
		.tx_data_i   (tx_data_i),
		.tx_charisk_i(tx_charisk_i),
		.tx_data_o   (tx_data_o),
		.tx_charisk_o(tx_charisk_o)
	);

endmodule

// File: verif/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD = 20,
	parameter int RST_CYCLES = 5
) (
	input  logic rst_req_i, // rising edge requests another reset
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		forever begin
			rst_o = 1'b1;
			repeat (RST_CYCLES) @(posedge clk_o);
			#2 rst_o = 1'b0;
			@(posedge rst_req_i);
		end
	end

endmodule

// File: verif/gt_bringup_props.sv
`timescale 1ns/1ps

module gt_bringup_props (
	input logic       CPLLLOCKDETCLK,
	input logic       reset,
	input logic [5:0] step_reset_o,
	input logic [5:0] step_done_o,
	input logic [2:0] state_o
);

	logic [5:0] done_q;
	logic [5:0] new_bits;
	int fail_cnt = 0;

	always_ff @(posedge CPLLLOCKDETCLK or posedge reset) begin
		if (reset) begin
			done_q <= '0;
		end else begin
			done_q <= step_done_o;
		end
	end

	assign new_bits = step_done_o & ~done_q;

	// the step in reset is always the first step not yet done
	a_onehot_reset: assert property (@(posedge CPLLLOCKDETCLK) disable iff (reset)
		$onehot0(step_reset_o)
		&& ((step_reset_o == 6'd0) || (step_done_o == step_reset_o - 6'd1)))
		else begin
			fail_cnt++;
			$error("step reset not one-hot or not the next step");
		end

	// a new done bit needs all lower bits already set
	a_done_order: assert property (@(posedge CPLLLOCKDETCLK) disable iff (reset)
		(new_bits != 6'd0) |-> ($onehot(new_bits) && (((new_bits - 6'd1) & ~done_q) == 6'd0)))
		else begin
			fail_cnt++;
			$error("step done set out of order");
		end

	a_idle_quiet: assert property (@(posedge CPLLLOCKDETCLK) disable iff (reset)
		(state_o == 3'd0) |-> (step_reset_o == 6'd0) ##1 (step_reset_o == 6'd1))
		else begin
			fail_cnt++;
			$error("step reset high in idle or step 0 not started after idle");
		end

endmodule

// File: verif/gt_bringup_tb.sv
`timescale 1ns/1ps

module gt_bringup_tb;

	localparam int DWIDTH = 16;
	localparam int STEP_TIMEOUT = 64;
	localparam int NSTEP = gt_bringup_pkg::NSTEP;
	localparam int NROW = 6;
	localparam int ROW_CYC = NSTEP * (4 + gt_bringup_pkg::READY_LEN + STEP_TIMEOUT);
	localparam int LIMIT_NS = (NROW * ROW_CYC + 2000) * 20;

	typedef struct packed {
		logic [5:0] mask;
		logic [7:0] cpll_dly; // cycles after reset release
		logic [7:0] txrx_dly;
		logic [1:0] tx_np;    // phase-align pulses after delay reset
		logic [1:0] rx_np;
		logic [3:0] glitch;   // cdr low cycles, 0 = none
		logic [5:0] exp_done;
		logic [5:0] exp_seen;
		logic       exp_rdone;
		logic       exp_restart;
	} row_t;

	row_t table_r [NROW];

	logic CPLLLOCKDETCLK;
	logic reset;
	logic rst_req;
	logic [5:0] mask_i;
	logic cpll_lock_i, cpll_fbclk_lost_i, cpll_refclk_lost_i;
	logic tx_reset_done_i, rx_reset_done_i, mmcm_locked_i;
	logic tx_phalign_done_i, rx_phalign_done_i;
	logic rx_cdr_lock_i, rx_elec_idle_i;
	logic [1:0] rx_notintable_i, rx_disperr_i;
	logic [DWIDTH-1:0] tx_data_i;
	logic [1:0] tx_charisk_i;
	logic [5:0] gt_reset_o, step_done_o, criteria_o;
	logic [2:0] seq_state_o;
	logic cdr_locked_o, reset_done_o;
	logic [DWIDTH-1:0] tx_data_o;
	logic [1:0] tx_charisk_o;

	row_t cur;
	int seed = 32'h8037;
	int errors = 0;
	int cpll_cnt, txrx_cnt, tx_t, rx_t, last_idx;
	int plen [NSTEP];
	logic [5:0] rst_q;
	logic [5:0] seen;
	logic restart_seen;

	tb_clkgen u_tb_clkgen (
		.rst_req_i(rst_req),
		.clk_o    (CPLLLOCKDETCLK),
		.rst_o    (reset)
	);

	gt_bringup_top #(
		.DWIDTH      (DWIDTH),
		.STEP_TIMEOUT(STEP_TIMEOUT)
	) u_gt_bringup_top (.*);

	bind chain_reset_seq gt_bringup_props u_props (
		.CPLLLOCKDETCLK(CPLLLOCKDETCLK),
		.reset         (reset),
		.step_reset_o  (step_reset_o),
		.step_done_o   (step_done_o),
		.state_o       (state_o)
	);

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch");
		end
	endtask

	// transceiver status model and reset pulse monitor, all at clock + 2 ns
	always @(posedge CPLLLOCKDETCLK) begin
		#2;
		if (reset) begin
			cpll_cnt = 0;
			txrx_cnt = 0;
			tx_t = 0;
			rx_t = 0;
			last_idx = -1;
			rst_q = '0;
			seen = '0;
			restart_seen = 1'b0;
			for (int k = 0; k < NSTEP; k++) plen[k] = 0;
		end else begin
			seen = seen | step_done_o;
			for (int k = 0; k < NSTEP; k++) begin
				if (gt_reset_o[k]) begin
					if (!rst_q[k]) begin
						check_val($sformatf("gt_reset_o[%0d] mask", k), 1, cur.mask[k]);
						if (k <= last_idx) restart_seen = 1'b1;
						last_idx = k;
						plen[k] = 0;
					end
					plen[k]++;
				end else if (rst_q[k]) begin
					check_val($sformatf("gt_reset_o[%0d] len", k), plen[k],
						gt_bringup_pkg::RESET_LEN[k]);
				end
			end
			if (gt_reset_o[0]) cpll_cnt = 0;
			else if (cpll_cnt < 255) cpll_cnt++;
			if (gt_reset_o[1] || gt_reset_o[2]) txrx_cnt = 0;
			else if (txrx_cnt < 255) txrx_cnt++;
			if (rst_q[3] && !gt_reset_o[3]) tx_t = 1;
			else if (tx_t > 0 && tx_t < 100) tx_t++;
			if (rst_q[4] && !gt_reset_o[4]) rx_t = 1;
			else if (rx_t > 0 && rx_t < 100) rx_t++;
			rst_q = gt_reset_o;
		end
		cpll_lock_i = !reset && (cpll_cnt > cur.cpll_dly);
		tx_reset_done_i = !reset && (txrx_cnt > cur.txrx_dly);
		rx_reset_done_i = tx_reset_done_i;
		tx_phalign_done_i = (tx_t == 3 && cur.tx_np >= 1) || (tx_t == 6 && cur.tx_np >= 2);
		rx_phalign_done_i = (rx_t == 3 && cur.rx_np >= 1) || (rx_t == 6 && cur.rx_np >= 2);
	end

	initial begin
		#(LIMIT_NS);
		$display("timeout, the bring-up never finished");
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

	initial begin
		wait (u_gt_bringup_top.u_chain_reset_seq.u_props.fail_cnt != 0);
		$display("a sequencer assertion failed");
		$display("=== FAIL ===");
		$fatal(1, "assertion failure");
	end

	initial begin
		int drop;
		table_r[0] = {6'h3F, 8'd3, 8'd3, 2'd2, 2'd2, 4'd2, 6'h3F, 6'h3F, 1'b1, 1'b0};
		table_r[1] = {6'h3F, 8'd3, 8'd3, 2'd1, 2'd2, 4'd0, 6'h00, 6'h07, 1'b0, 1'b1};
		table_r[2] = {6'h3F, 8'd80, 8'd3, 2'd2, 2'd2, 4'd0, 6'h00, 6'h00, 1'b0, 1'b1};
		table_r[3] = {6'h07, 8'd3, 8'd3, 2'd0, 2'd0, 4'd4, 6'h3F, 6'h3F, 1'b1, 1'b0};
		table_r[4] = {6'h3F, 8'd3, 8'd3, 2'd2, 2'd1, 4'd0, 6'h00, 6'h0F, 1'b0, 1'b1};
		table_r[5] = {6'h3E, 8'd3, 8'd3, 2'd2, 2'd2, 4'd3, 6'h3F, 6'h3F, 1'b1, 1'b0};
		cur = table_r[0];
		rst_req = 1'b0;
		mask_i = cur.mask;
		cpll_lock_i = 1'b0;
		cpll_fbclk_lost_i = 1'b0;
		cpll_refclk_lost_i = 1'b0;
		tx_reset_done_i = 1'b0;
		rx_reset_done_i = 1'b0;
		mmcm_locked_i = 1'b1;
		tx_phalign_done_i = 1'b0;
		rx_phalign_done_i = 1'b0;
		rx_cdr_lock_i = 1'b1;
		rx_elec_idle_i = 1'b0;
		rx_notintable_i = '0;
		rx_disperr_i = '0;
		tx_data_i = '0;
		tx_charisk_i = '0;

		for (int r = 0; r < NROW; r++) begin
			if (r > 0) begin
				@(posedge CPLLLOCKDETCLK);
				#2 rst_req = 1'b1;
				@(posedge CPLLLOCKDETCLK);
				#2 rst_req = 1'b0;
				cur = table_r[r]; // reset already held here
				mask_i = cur.mask;
			end
			wait (!reset);
			check_val("seq_state_o", seq_state_o, gt_bringup_pkg::IDLE);
			check_val("step_done_o", step_done_o, 6'h00);
			check_val("gt_reset_o", gt_reset_o, 6'h00);
			@(posedge CPLLLOCKDETCLK);
			#3;
			// comma word while bring-up runs
			check_val("tx_data_o", tx_data_o, 32'h00BC);
			check_val("tx_charisk_o", tx_charisk_o, 32'h1);
			do begin
				@(posedge CPLLLOCKDETCLK);
				#3;
			end while (!(reset_done_o || restart_seen));
			check_val("restart", restart_seen, cur.exp_restart);
			check_val("reset_done_o", reset_done_o, cur.exp_rdone);
			check_val("step_done_o", step_done_o, cur.exp_done);
			check_val("step_done seen", seen, cur.exp_seen);
			check_val("seq_state_o", seq_state_o,
				cur.exp_rdone ? gt_bringup_pkg::DONE : gt_bringup_pkg::RESET);
			check_val("criteria_o masked", criteria_o & ~cur.mask, ~cur.mask & 6'h3F);
			if (reset_done_o) begin
				repeat (4) begin
					@(posedge CPLLLOCKDETCLK);
					#2;
					tx_data_i = $random(seed);
					tx_charisk_i = $random(seed);
					#1;
					check_val("tx_data_o", tx_data_o, tx_data_i);
					check_val("tx_charisk_o", tx_charisk_o, tx_charisk_i);
				end
			end
			if (cur.glitch != 0) begin
				drop = 0;
				@(posedge CPLLLOCKDETCLK);
				#2 rx_cdr_lock_i = 1'b0;
				// cdr held low for glitch samples only
				for (int c = 0; c < cur.glitch + 3; c++) begin
					@(posedge CPLLLOCKDETCLK);
					#2;
					if (c == cur.glitch - 1) rx_cdr_lock_i = 1'b1;
					#1;
					if (!cdr_locked_o) drop = 1;
				end
				check_val("cdr_locked_o drop", drop, cur.glitch >= gt_bringup_pkg::LOCK_MAX);
			end
		end

		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: compile.f
design/gt_bringup_pkg.sv
design/chain_reset_seq.sv
design/align_done_tracker.sv
design/cdr_lock_filter.sv
design/bringup_status.sv
design/tx_word_gate.sv
design/gt_bringup_top.sv
verif/tb_clkgen.sv
verif/gt_bringup_props.sv
verif/gt_bringup_tb.sv

// File: Bender.yml
package:
  name: gt_bringup

sources:
  - design/gt_bringup_pkg.sv
  - design/chain_reset_seq.sv
  - design/align_done_tracker.sv
  - design/cdr_lock_filter.sv
  - design/bringup_status.sv
  - design/tx_word_gate.sv
  - design/gt_bringup_top.sv
  - target: test
    files:
      - verif/tb_clkgen.sv
      - verif/gt_bringup_props.sv
      - verif/gt_bringup_tb.sv
